// ==== design/rv_core_params.svh ====
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// data and address width
`define XLEN 32

// instruction word width
`define INST_W 32

// register index width and architectural register count
`define REG_ADDR_W 5
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0 used to fill flushed slots
`define NOP_INST 32'h0000_0013

`endif

// ==== design/rv_core_pkg.sv ====
`include "rv_core_params.svh"

package rv_core_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`INST_W-1:0] inst_t;

  // alu functions
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // where the writeback value comes from
  typedef enum logic [1:0] {
    RES_ALU,
    RES_LOAD,
    RES_LINK
  } res_src_e;

  // conditional branch type, none for everything else
  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE
  } br_cond_e;

endpackage

// ==== design/rv_pipe_ifs.sv ====
`timescale 1ns/1ns

// fetch to decode
interface if_id_if;
  rv_core_pkg::word_t pc;
  rv_core_pkg::inst_t inst;
  logic               valid;

  modport src (output pc, inst, valid);
  modport dst (input pc, inst, valid);
endinterface

// decode to execute
interface id_ex_if;
  logic                   valid;
  rv_core_pkg::word_t     pc;
  rv_core_pkg::reg_addr_t rs1;
  rv_core_pkg::reg_addr_t rs2;
  rv_core_pkg::reg_addr_t rd;
  rv_core_pkg::word_t     rs1_val;
  rv_core_pkg::word_t     rs2_val;
  rv_core_pkg::word_t     imm;
  rv_core_pkg::alu_op_e   alu_op;
  logic                   use_imm;
  logic                   use_pc;
  logic                   reg_write;
  logic                   mem_read;
  logic                   mem_write;
  rv_core_pkg::res_src_e  res_src;
  rv_core_pkg::br_cond_e  br_cond;
  logic                   jal;

  modport src (output valid, pc, rs1, rs2, rd, rs1_val, rs2_val, imm, alu_op, use_imm,
               use_pc, reg_write, mem_read, mem_write, res_src, br_cond, jal);
  modport dst (input valid, pc, rs1, rs2, rd, rs1_val, rs2_val, imm, alu_op, use_imm,
               use_pc, reg_write, mem_read, mem_write, res_src, br_cond, jal);
endinterface

// execute to memory
interface ex_mem_if;
  logic                   valid;
  rv_core_pkg::word_t     alu_result;
  rv_core_pkg::word_t     store_data;
  rv_core_pkg::reg_addr_t rd;
  logic                   reg_write;
  logic                   mem_read;
  logic                   mem_write;
  rv_core_pkg::res_src_e  res_src;
  rv_core_pkg::word_t     link_pc;
  logic                   take_branch;
  rv_core_pkg::word_t     target;

  modport src (output valid, alu_result, store_data, rd, reg_write, mem_read, mem_write,
               res_src, link_pc, take_branch, target);
  modport dst (input valid, alu_result, store_data, rd, reg_write, mem_read, mem_write,
               res_src, link_pc, take_branch, target);
endinterface

// writeback result, read by decode and execute
interface wb_if;
  logic                   valid;
  rv_core_pkg::reg_addr_t rd;
  rv_core_pkg::word_t     data;
  logic                   reg_write;

  modport src (output valid, rd, data, reg_write);
  modport dst (input valid, rd, data, reg_write);
endinterface

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module fetch_stage (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               stall_i,
  input  logic               redirect_i,
  input  rv_core_pkg::word_t redirect_pc_i,
  output rv_core_pkg::word_t imem_addr_o,
  input  rv_core_pkg::inst_t imem_data_i,
  if_id_if.src               out
);

  rv_core_pkg::word_t pc;

  assign imem_addr_o = pc;

  // redirect beats a load-use hold
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc <= `RESET_PC;
    end else if (redirect_i) begin
      pc <= redirect_pc_i;
    end else if (!stall_i) begin
      pc <= pc + `XLEN'(4);
    end
  end

  // ====================
  // IF/ID register
  // ====================
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out.valid <= 1'b0;
      out.pc    <= `RESET_PC;
      out.inst  <= `NOP_INST;
    end else if (redirect_i) begin
      // wrong-path fetch becomes a nop bubble
      out.valid <= 1'b0;
      out.inst  <= `NOP_INST;
    end else if (!stall_i) begin
      out.valid <= 1'b1;
      out.pc    <= pc;
      out.inst  <= imem_data_i;
    end
  end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  if_id_if.dst                   in,
  wb_if.dst                      wb,
  input  rv_core_pkg::reg_addr_t ex_rd_i,
  input  logic                   ex_mem_read_i,
  output logic                   stall_o,
  id_ex_if.src                   out
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic                   funct7_5;
  rv_core_pkg::reg_addr_t rs1;
  rv_core_pkg::reg_addr_t rs2;
  rv_core_pkg::word_t     imm;
  rv_core_pkg::word_t     rs1_val;
  rv_core_pkg::word_t     rs2_val;
  rv_core_pkg::alu_op_e   alu_op;
  rv_core_pkg::res_src_e  res_src;
  rv_core_pkg::br_cond_e  br_cond;
  logic                   use_imm;
  logic                   use_pc;
  logic                   reg_write;
  logic                   mem_read;
  logic                   mem_write;
  logic                   jal;
  logic                   wb_we;
  logic                   load;
  rv_core_pkg::word_t     regs [1:`REG_COUNT-1];

  assign opcode   = in.inst[6:0];
  assign funct3   = in.inst[14:12];
  assign funct7_5 = in.inst[30];
  // lui reads x0 so the alu adds zero to the immediate
  assign rs1      = (opcode == OPC_LUI) ? '0 : in.inst[19:15];
  assign rs2      = in.inst[24:20];

  // control decode
  always_comb begin
    res_src   = rv_core_pkg::RES_ALU;
    br_cond   = rv_core_pkg::BR_NONE;
    use_imm   = 1'b1;
    use_pc    = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    jal       = 1'b0;
    unique case (funct3)
      3'b000:  alu_op = (opcode == OPC_OP && funct7_5) ? rv_core_pkg::ALU_SUB
                                                       : rv_core_pkg::ALU_ADD;
      3'b001:  alu_op = rv_core_pkg::ALU_SLL;
      3'b010:  alu_op = rv_core_pkg::ALU_SLT;
      3'b011:  alu_op = rv_core_pkg::ALU_SLTU;
      3'b100:  alu_op = rv_core_pkg::ALU_XOR;
      3'b101:  alu_op = funct7_5 ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  alu_op = rv_core_pkg::ALU_OR;
      default: alu_op = rv_core_pkg::ALU_AND;
    endcase
    case (opcode)
      OPC_OP: begin
        use_imm   = 1'b0;
        reg_write = 1'b1;
      end
      OPC_OP_IMM: reg_write = 1'b1;
      OPC_LUI, OPC_AUIPC: begin
        alu_op    = rv_core_pkg::ALU_ADD;
        use_pc    = (opcode == OPC_AUIPC);
        reg_write = 1'b1;
      end
      OPC_LOAD, OPC_STORE: begin
        alu_op    = rv_core_pkg::ALU_ADD;
        mem_read  = (opcode == OPC_LOAD);
        mem_write = (opcode == OPC_STORE);
        reg_write = (opcode == OPC_LOAD);
        res_src   = rv_core_pkg::RES_LOAD;
      end
      OPC_BRANCH: begin
        use_imm = 1'b0;
        case (funct3)
          3'b000:  br_cond = rv_core_pkg::BR_EQ;
          3'b001:  br_cond = rv_core_pkg::BR_NE;
          3'b100:  br_cond = rv_core_pkg::BR_LT;
          3'b101:  br_cond = rv_core_pkg::BR_GE;
          default: br_cond = rv_core_pkg::BR_NONE;
        endcase
      end
      OPC_JAL: begin
        jal       = 1'b1;
        reg_write = 1'b1;
        res_src   = rv_core_pkg::RES_LINK;
      end
      default: use_imm = 1'b1;
    endcase
  end

  // immediate by format
  always_comb begin
    case (opcode)
      OPC_STORE:  imm = {{20{in.inst[31]}}, in.inst[31:25], in.inst[11:7]};
      OPC_BRANCH: imm = {{19{in.inst[31]}}, in.inst[31], in.inst[7], in.inst[30:25],
                         in.inst[11:8], 1'b0};
      OPC_LUI, OPC_AUIPC: imm = {in.inst[31:12], 12'b0};
      OPC_JAL:    imm = {{11{in.inst[31]}}, in.inst[31], in.inst[19:12], in.inst[20],
                         in.inst[30:21], 1'b0};
      default:    imm = {{20{in.inst[31]}}, in.inst[31:20]};
    endcase
  end

  // ====================
  // register file
  // ====================
  assign wb_we = wb.valid && wb.reg_write && (wb.rd != '0);

  always_ff @(posedge clk) begin
    if (wb_we) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // same-cycle writeback wins over the stored value
  function automatic rv_core_pkg::word_t read_reg(input rv_core_pkg::reg_addr_t addr);
    rv_core_pkg::word_t val;
    if (addr == '0) begin
      val = '0;
    end else if (wb_we && wb.rd == addr) begin
      val = wb.data;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  assign rs1_val = read_reg(rs1);
  assign rs2_val = read_reg(rs2);

  // load in execute feeding this instruction
  assign stall_o = in.valid && ex_mem_read_i && (ex_rd_i != '0) &&
                   ((ex_rd_i == rs1) || (ex_rd_i == rs2));
  assign load    = in.valid && !stall_o && !flush_i;

  // ====================
  // ID/EX register
  // ====================
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out.valid     <= 1'b0;
      out.reg_write <= 1'b0;
      out.mem_read  <= 1'b0;
      out.mem_write <= 1'b0;
      out.jal       <= 1'b0;
      out.br_cond   <= rv_core_pkg::BR_NONE;
    end else begin
      out.valid     <= load;
      out.reg_write <= load && reg_write;
      out.mem_read  <= load && mem_read;
      out.mem_write <= load && mem_write;
      out.jal       <= load && jal;
      out.br_cond   <= load ? br_cond : rv_core_pkg::BR_NONE;
    end
  end

  always_ff @(posedge clk) begin
    out.pc      <= in.pc;
    out.rs1     <= rs1;
    out.rs2     <= rs2;
    out.rd      <= in.inst[11:7];
    out.rs1_val <= rs1_val;
    out.rs2_val <= rs2_val;
    out.imm     <= imm;
    out.alu_op  <= alu_op;
    out.use_imm <= use_imm;
    out.use_pc  <= use_pc;
    out.res_src <= res_src;
  end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module execute_stage (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  id_ex_if.dst                   in,
  input  logic                   fwd_mem_valid_i,
  input  rv_core_pkg::reg_addr_t fwd_mem_rd_i,
  input  rv_core_pkg::word_t     fwd_mem_data_i,
  wb_if.dst                      wb,
  ex_mem_if.src                  out
);

  rv_core_pkg::word_t rs1_fwd;
  rv_core_pkg::word_t rs2_fwd;
  rv_core_pkg::word_t op_a;
  rv_core_pkg::word_t op_b;
  rv_core_pkg::word_t alu_result;
  logic               wb_fwd;
  logic               cond_met;
  logic               load;

  assign wb_fwd = wb.valid && wb.reg_write;

  // memory stage is younger, so it is checked first
  function automatic rv_core_pkg::word_t fwd(input rv_core_pkg::reg_addr_t rs,
                                             input rv_core_pkg::word_t rf_val);
    rv_core_pkg::word_t val;
    if (rs == '0) begin
      val = rf_val;
    end else if (fwd_mem_valid_i && fwd_mem_rd_i == rs) begin
      val = fwd_mem_data_i;
    end else if (wb_fwd && wb.rd == rs) begin
      val = wb.data;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  assign rs1_fwd = fwd(in.rs1, in.rs1_val);
  assign rs2_fwd = fwd(in.rs2, in.rs2_val);
  assign op_a    = in.use_pc ? in.pc : rs1_fwd;
  assign op_b    = in.use_imm ? in.imm : rs2_fwd;

  // ====================
  // ALU
  // ====================
  always_comb begin
    case (in.alu_op)
      rv_core_pkg::ALU_SUB:  alu_result = op_a - op_b;
      rv_core_pkg::ALU_SLL:  alu_result = op_a << op_b[4:0];
      rv_core_pkg::ALU_SLT:  alu_result = `XLEN'($signed(op_a) < $signed(op_b));
      rv_core_pkg::ALU_SLTU: alu_result = `XLEN'(op_a < op_b);
      rv_core_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
      rv_core_pkg::ALU_SRL:  alu_result = op_a >> op_b[4:0];
      rv_core_pkg::ALU_SRA:  alu_result = $signed(op_a) >>> op_b[4:0];
      rv_core_pkg::ALU_OR:   alu_result = op_a | op_b;
      rv_core_pkg::ALU_AND:  alu_result = op_a & op_b;
      default:               alu_result = op_a + op_b;
    endcase
  end

  // branch compare on forwarded operands
  always_comb begin
    case (in.br_cond)
      rv_core_pkg::BR_EQ: cond_met = (rs1_fwd == rs2_fwd);
      rv_core_pkg::BR_NE: cond_met = (rs1_fwd != rs2_fwd);
      rv_core_pkg::BR_LT: cond_met = ($signed(rs1_fwd) < $signed(rs2_fwd));
      rv_core_pkg::BR_GE: cond_met = ($signed(rs1_fwd) >= $signed(rs2_fwd));
      default:            cond_met = 1'b0;
    endcase
  end

  assign load = in.valid && !flush_i;

  // ====================
  // EX/MEM register
  // ====================
  // jal rides on take_branch, memory sees a single redirect request
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out.valid       <= 1'b0;
      out.reg_write   <= 1'b0;
      out.mem_read    <= 1'b0;
      out.mem_write   <= 1'b0;
      out.take_branch <= 1'b0;
    end else begin
      out.valid       <= load;
      out.reg_write   <= load && in.reg_write;
      out.mem_read    <= load && in.mem_read;
      out.mem_write   <= load && in.mem_write;
      out.take_branch <= load && (cond_met || in.jal);
    end
  end

  always_ff @(posedge clk) begin
    out.alu_result <= alu_result;
    out.store_data <= rs2_fwd;
    out.rd         <= in.rd;
    out.res_src    <= in.res_src;
    out.link_pc    <= in.pc + `XLEN'(4);
    out.target     <= in.pc + in.imm;
  end

endmodule

// ==== design/memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage (
  input  logic                   clk,
  input  logic                   rst_n_i,
  ex_mem_if.dst                  in,
  output rv_core_pkg::word_t     dmem_addr_o,
  output rv_core_pkg::word_t     dmem_wdata_o,
  output logic                   dmem_we_o,
  output logic                   dmem_re_o,
  input  rv_core_pkg::word_t     dmem_rdata_i,
  output logic                   redirect_o,
  output rv_core_pkg::word_t     redirect_pc_o,
  output logic                   flush_o,
  output logic                   fwd_mem_valid_o,
  output rv_core_pkg::reg_addr_t fwd_mem_rd_o,
  output rv_core_pkg::word_t     fwd_mem_data_o,
  wb_if.src                      wb
);

  rv_core_pkg::word_t    result;
  rv_core_pkg::word_t    result_q;
  rv_core_pkg::res_src_e res_src_q;

  assign dmem_addr_o  = in.alu_result;
  assign dmem_wdata_o = in.store_data;
  assign dmem_we_o    = in.valid && in.mem_write;
  assign dmem_re_o    = in.valid && in.mem_read;

  // taken branch or jal, kills the three younger slots
  assign redirect_o    = in.valid && in.take_branch;
  assign redirect_pc_o = in.target;
  assign flush_o       = redirect_o;

  assign result = (in.res_src == rv_core_pkg::RES_LINK) ? in.link_pc : in.alu_result;

  // load data is not here yet, so loads never forward from this stage
  assign fwd_mem_valid_o = in.valid && in.reg_write && (in.rd != '0) &&
                           (in.res_src != rv_core_pkg::RES_LOAD);
  assign fwd_mem_rd_o    = in.rd;
  assign fwd_mem_data_o  = result;

  // ====================
  // MEM/WB register
  // ====================
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb.valid     <= 1'b0;
      wb.reg_write <= 1'b0;
    end else begin
      wb.valid     <= in.valid;
      wb.reg_write <= in.valid && in.reg_write;
    end
  end

  always_ff @(posedge clk) begin
    wb.rd     <= in.rd;
    res_src_q <= in.res_src;
    result_q  <= result;
  end

  // writeback mux, read data lands one cycle after the address
  assign wb.data = (res_src_q == rv_core_pkg::RES_LOAD) ? dmem_rdata_i : result_q;

endmodule

// ==== design/rv_core_top.sv ====
`timescale 1ns/1ns

module rv_core_top (
  input  logic                   clk,
  input  logic                   rst_n_i,
  output rv_core_pkg::word_t     imem_addr_o,
  input  rv_core_pkg::inst_t     imem_data_i,
  output rv_core_pkg::word_t     dmem_addr_o,
  output rv_core_pkg::word_t     dmem_wdata_o,
  output logic                   dmem_we_o,
  output logic                   dmem_re_o,
  input  rv_core_pkg::word_t     dmem_rdata_i,
  output logic                   wb_valid_o,
  output rv_core_pkg::reg_addr_t wb_rd_o,
  output rv_core_pkg::word_t     wb_data_o
);

  if_id_if  if_id ();
  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();
  wb_if     wb ();

  logic                   stall;
  logic                   redirect;
  rv_core_pkg::word_t     redirect_pc;
  logic                   flush;
  logic                   fwd_mem_valid;
  rv_core_pkg::reg_addr_t fwd_mem_rd;
  rv_core_pkg::word_t     fwd_mem_data;

  fetch_stage u_fetch (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .imem_addr_o   (imem_addr_o),
    .imem_data_i   (imem_data_i),
    .out           (if_id)
  );

  // load-use check looks at the ID/EX outputs
  decode_stage u_decode (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush),
    .in            (if_id),
    .wb            (wb),
    .ex_rd_i       (id_ex.rd),
    .ex_mem_read_i (id_ex.mem_read),
    .stall_o       (stall),
    .out           (id_ex)
  );

  execute_stage u_execute (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush),
    .in              (id_ex),
    .fwd_mem_valid_i (fwd_mem_valid),
    .fwd_mem_rd_i    (fwd_mem_rd),
    .fwd_mem_data_i  (fwd_mem_data),
    .wb              (wb),
    .out             (ex_mem)
  );

  memory_stage u_memory (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .in              (ex_mem),
    .dmem_addr_o     (dmem_addr_o),
    .dmem_wdata_o    (dmem_wdata_o),
    .dmem_we_o       (dmem_we_o),
    .dmem_re_o       (dmem_re_o),
    .dmem_rdata_i    (dmem_rdata_i),
    .redirect_o      (redirect),
    .redirect_pc_o   (redirect_pc),
    .flush_o         (flush),
    .fwd_mem_valid_o (fwd_mem_valid),
    .fwd_mem_rd_o    (fwd_mem_rd),
    .fwd_mem_data_o  (fwd_mem_data),
    .wb              (wb)
  );

  // retire port, x0 writes stay hidden
  assign wb_valid_o = wb.valid && wb.reg_write && (wb.rd != '0);
  assign wb_rd_o    = wb.rd;
  assign wb_data_o  = wb.data;

endmodule

// ==== verification/rv_core_tb_prog.svh ====
`ifndef RV_CORE_TB_PROG_SVH
`define RV_CORE_TB_PROG_SVH

task automatic write_program();
  prog_len = 0;
  // dependent alu chain forwarding from memory and writeback
  put_inst(i_type(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5));
  put_inst(i_type(OPC_OP_IMM, 3'b000, 5'd2, 5'd1, 12'd3));
  put_inst(r_type(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
  put_inst(r_type(7'b0100000, 3'b000, 5'd4, 5'd3, 5'd1));
  put_inst(i_type(OPC_OP_IMM, 3'b001, 5'd5, 5'd4, 12'd2));
  put_inst(i_type(OPC_OP_IMM, 3'b000, 5'd6, 5'd0, 12'hff0));
  // srai x7, x6, 2
  put_inst(i_type(OPC_OP_IMM, 3'b101, 5'd7, 5'd6, 12'h402));
  put_inst(r_type(7'b0000000, 3'b010, 5'd8, 5'd6, 5'd1));
  put_inst(i_type(OPC_OP_IMM, 3'b000, 5'd0, 5'd1, 12'd7));
  // lui at 0x24 and auipc at 0x28
  put_inst(u_type(OPC_LUI, 5'd9, 20'h12345));
  put_inst(u_type(OPC_AUIPC, 5'd10, 20'h00001));
  // store, load with a load-use consumer, load of an untouched word
  put_inst(s_type(5'd9, 5'd0, 12'd8));
  put_inst(i_type(OPC_LOAD, 3'b010, 5'd11, 5'd0, 12'd8));
  put_inst(r_type(7'b0000000, 3'b000, 5'd12, 5'd11, 5'd1));
  put_inst(i_type(OPC_LOAD, 3'b010, 5'd13, 5'd0, 12'd16));
  // ====================
  // beq taken to 0x48, bne falls through, blt taken to 0x58, bge falls through
  put_inst(b_type(3'b000, 5'd1, 5'd1, 13'd12));
  put_inst(i_type(OPC_OP_IMM, 3'b000, 5'd14, 5'd0, 12'd1));
  put_inst(i_type(OPC_OP_IMM, 3'b000, 5'd14, 5'd0, 12'd2));
  put_inst(b_type(3'b001, 5'd2, 5'd4, 13'd8));
  put_inst(i_type(OPC_OP_IMM, 3'b000, 5'd15, 5'd0, 12'd21));
  put_inst(b_type(3'b100, 5'd6, 5'd1, 13'd8));
  put_inst(i_type(OPC_OP_IMM, 3'b000, 5'd15, 5'd0, 12'd99));
  put_inst(b_type(3'b101, 5'd6, 5'd1, 13'd8));
  put_inst(i_type(OPC_OP_IMM, 3'b000, 5'd16, 5'd13, 12'd1));
  // jal at 0x60 to 0x6c and then a self loop
  put_inst(j_type(5'd17, 21'd12));
  put_inst(i_type(OPC_OP_IMM, 3'b000, 5'd18, 5'd0, 12'd1));
  put_inst(i_type(OPC_OP_IMM, 3'b000, 5'd18, 5'd0, 12'd2));
  put_inst(i_type(OPC_OP_IMM, 3'b000, 5'd19, 5'd17, 12'd4));
  put_inst(j_type(5'd0, 21'd0));
endtask

task automatic list_expected();
  push_expected(5'd1, 32'd5);
  push_expected(5'd2, 32'd8);
  push_expected(5'd3, 32'd13);
  push_expected(5'd4, 32'd8);
  push_expected(5'd5, 32'd32);
  push_expected(5'd6, 32'hffff_fff0);
  push_expected(5'd7, 32'hffff_fffc);
  push_expected(5'd8, 32'd1);
  push_expected(5'd9, 32'h1234_5000);
  push_expected(5'd10, 32'h0000_1028);
  push_expected(5'd11, 32'h1234_5000);
  push_expected(5'd12, 32'h1234_5005);
  // fill value of byte address 0x10
  push_expected(5'd13, 32'hffef_0010);
  push_expected(5'd15, 32'd21);
  push_expected(5'd16, 32'hffef_0011);
  push_expected(5'd17, 32'h0000_0064);
  push_expected(5'd19, 32'h0000_0068);
endtask

`endif

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_core_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DELAY  = 2;
  localparam int DRAIN_CYCLES = 16;
  localparam int IMEM_WORDS   = 64;
  localparam int DMEM_WORDS   = 64;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;

  logic                   clk;
  logic                   rst_n_i;
  rv_core_pkg::word_t     imem_addr;
  rv_core_pkg::inst_t     imem_data;
  rv_core_pkg::word_t     dmem_addr;
  rv_core_pkg::word_t     dmem_wdata;
  logic                   dmem_we;
  logic                   dmem_re;
  rv_core_pkg::word_t     dmem_rdata;
  logic                   wb_valid;
  rv_core_pkg::reg_addr_t wb_rd;
  rv_core_pkg::word_t     wb_data;

  rv_core_pkg::inst_t     imem [IMEM_WORDS];
  rv_core_pkg::word_t     dmem [DMEM_WORDS];
  int                     prog_len;
  rv_core_pkg::reg_addr_t exp_rd [$];
  rv_core_pkg::word_t     exp_data [$];
  int                     pass_count;
  int                     fail_count;
  int                     retired;
  logic                   tables_ready;

  // memory request seen in the previous cycle
  logic                   req_we;
  logic                   req_re;
  rv_core_pkg::word_t     req_addr;
  rv_core_pkg::word_t     req_wdata;

  rv_core_top DUT (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .imem_addr_o  (imem_addr),
    .imem_data_i  (imem_data),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_we_o    (dmem_we),
    .dmem_re_o    (dmem_re),
    .dmem_rdata_i (dmem_rdata),
    .wb_valid_o   (wb_valid),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data)
  );

  // ====================
  // instruction encoders
  // ====================
  function automatic rv_core_pkg::inst_t r_type(input logic [6:0] funct7,
      input logic [2:0] funct3, input logic [4:0] rd, input logic [4:0] rs1,
      input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, OPC_OP};
  endfunction

  function automatic rv_core_pkg::inst_t i_type(input logic [6:0] opcode,
      input logic [2:0] funct3, input logic [4:0] rd, input logic [4:0] rs1,
      input logic [11:0] imm);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  // sw only
  function automatic rv_core_pkg::inst_t s_type(input logic [4:0] rs2, input logic [4:0] rs1,
      input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv_core_pkg::inst_t b_type(input logic [2:0] funct3,
      input logic [4:0] rs1, input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv_core_pkg::inst_t u_type(input logic [6:0] opcode,
      input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, opcode};
  endfunction

  function automatic rv_core_pkg::inst_t j_type(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // power-up content of a data word, unique per byte address
  function automatic rv_core_pkg::word_t fill_word(input logic [31:0] byte_addr);
    return {~byte_addr[15:0], byte_addr[15:0]};
  endfunction

  task automatic put_inst(input rv_core_pkg::inst_t inst);
    imem[prog_len[5:0]] = inst;
    prog_len++;
  endtask

  task automatic push_expected(input rv_core_pkg::reg_addr_t rd,
                               input rv_core_pkg::word_t data);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
  endtask

  `include "rv_core_tb_prog.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // combinational instruction memory, nops past the program end
  assign imem_data = (imem_addr[31:2] < 30'(prog_len)) ? imem[imem_addr[7:2]] : `NOP_INST;

  // data memory, read word shows up one cycle after the request
  initial begin
    dmem_rdata = '0;
    req_we     = 1'b0;
    req_re     = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = fill_word(32'(i) << 2);
    end
    forever begin
      @(negedge clk);
      req_we    = dmem_we;
      req_re    = dmem_re;
      req_addr  = dmem_addr;
      req_wdata = dmem_wdata;
      @(posedge clk);
      #DRIVE_DELAY;
      if (req_we === 1'b1) begin
        dmem[req_addr[7:2]] = req_wdata;
      end
      if (req_re === 1'b1) begin
        dmem_rdata = dmem[req_addr[7:2]];
      end
    end
  end

  // ====================
  // checking
  // ====================
  task automatic probe_quiet(inout int errs);
    if (wb_valid !== 1'b0) begin
      $display("[FAIL] %0t ns: wb_valid_o = %b, expected 0", $time, wb_valid);
      errs++;
    end
    if (dmem_we !== 1'b0) begin
      $display("[FAIL] %0t ns: dmem_we_o = %b, expected 0", $time, dmem_we);
      errs++;
    end
  endtask

  task automatic reset_sequence();
    int errs;
    errs = 0;
    repeat (RESET_CYCLES - 1) begin
      @(negedge clk);
      probe_quiet(errs);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;
    // nothing can retire before the first fetch reaches writeback
    repeat (3) begin
      @(negedge clk);
      probe_quiet(errs);
    end
    if (errs == 0) begin
      pass_count++;
      $display("[PASS] reset: no writeback or store during and after reset");
    end else begin
      fail_count++;
    end
  endtask

  task automatic wait_retire();
    @(negedge clk);
    while (wb_valid !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  task automatic compare_retire(input int idx);
    int errs;
    errs = 0;
    retired++;
    if (wb_rd !== exp_rd[idx]) begin
      $display("[FAIL] %0t ns: wb_rd_o = %0d, expected %0d (result %0d)",
               $time, wb_rd, exp_rd[idx], idx);
      errs++;
    end
    if (wb_data !== exp_data[idx]) begin
      $display("[FAIL] %0t ns: wb_data_o = 0x%08h, expected 0x%08h (result %0d)",
               $time, wb_data, exp_data[idx], idx);
      errs++;
    end
    if (errs == 0) begin
      pass_count++;
      $display("[PASS] result %0d: x%0d = 0x%08h", idx, wb_rd, wb_data);
    end else begin
      fail_count++;
    end
  endtask

  // skipped instructions and x0 writes must stay invisible
  task automatic watch_drain();
    int errs;
    errs = 0;
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      if (wb_valid === 1'b1) begin
        $display("[FAIL] unexpected writeback to x%0d (0x%08h) at %0t ns after the last result",
                 wb_rd, wb_data, $time);
        errs++;
      end
    end
    if (errs == 0) begin
      pass_count++;
      $display("[PASS] drain: no writeback after the last expected result");
    end else begin
      fail_count++;
    end
  endtask

  initial begin
    rst_n_i      = 1'b0;
    pass_count   = 0;
    fail_count   = 0;
    retired      = 0;
    tables_ready = 1'b0;
    write_program();
    list_expected();
    tables_ready = 1'b1;
    reset_sequence();
    for (int i = 0; i < exp_rd.size(); i++) begin
      wait_retire();
      compare_retire(i);
    end
    watch_drain();
    $display("%0d tests, %0d passed, %0d failed", pass_count + fail_count, pass_count,
             fail_count);
    if (fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog, ten cycles per expected result on top of reset
  initial begin
    wait (tables_ready === 1'b1);
    #((exp_rd.size() * 10 + RESET_CYCLES) * CLK_PERIOD);
    $display("timeout at %0t ns, only %0d of %0d results retired", $time, retired,
             exp_rd.size());
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+design
+incdir+verification
design/rv_core_pkg.sv
design/rv_pipe_ifs.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/rv_core_top.sv
verification/rv_core_tb.sv

// ==== Makefile ====
TB_TOP := rv_core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module rv_core_top
	verilator --lint-only --timing -f build.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TB_TOP) --Mdir obj_dir -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Simulation passed" sim.log || (echo "no pass message in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
